//--- packed_pe_top.f
+incdir+design
design/packed_pe_pkg.sv
design/packed_mult.sv
design/packed_mac.sv
design/mac_sequencer.sv
design/pe_apb_regs.sv
design/packed_pe_top.sv
bench/packed_pe_assertions.sv
bench/packed_pe_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the packed PE testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f packed_pe_top.f \
  --top-module packed_pe_tb -o packed_pe_sim

out=$(./obj_dir/packed_pe_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'

//--- bench/packed_pe_tb.sv
`default_nettype none

`include "packed_pe_defines.svh"

module packed_pe_tb;

  // Windows total 430 samples, at most 4 cycles each with gaps, plus register traffic
  localparam int MAX_CYCLES = 4000;

  logic                   clk;
  logic                   reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`PE_APB_AW-1:0]  paddr;
  logic [`PE_APB_DW-1:0]  pwdata;
  logic [`PE_APB_DW-1:0]  prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   sample_valid;
  logic                   sample_ready;
  logic [`PE_PIXELS-1:0]  sample_pixels;
  logic [`PE_WEIGHTS-1:0] sample_weights;

  integer     seed;
  int         cycles = 0;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         assert_fails;
  // Expected count per lane, lane i+4j for pixel i and weight j
  logic [7:0] ref_count [`PE_LANES];

  packed_pe_top packed_pe_top_i (
    .clk            (clk),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .sample_valid   (sample_valid),
    .sample_ready   (sample_ready),
    .sample_pixels  (sample_pixels),
    .sample_weights (sample_weights)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus and stream drivers
  //////////////////////////////////////////////////////////////////////
  // Called and returns one time unit after a rising edge
  task automatic apb_transfer(input logic wr, input logic [`PE_APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // Access phase ends at the next edge
    #1;
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic void count_sample(input logic [3:0] pix, input logic [3:0] wgt);
    for (int j = 0; j < `PE_WEIGHTS; j++) begin
      for (int i = 0; i < `PE_PIXELS; i++) begin
        if (pix[i] && wgt[j]) begin
          ref_count[i + 4 * j] = ref_count[i + 4 * j] + 8'd1;
        end
      end
    end
  endfunction

  task automatic send_window(input int count, input logic ones, input logic gaps);
    logic [31:0] r;
    logic [3:0]  pix;
    logic [3:0]  wgt;
    int          idle;
    for (int s = 0; s < count; s++) begin
      r    = $random(seed);
      idle = gaps ? int'(r[25:24]) : 0;
      // Three nibbles ORed so most bits are set and lanes climb fast
      pix  = ones ? 4'hF : (r[3:0] | r[7:4] | r[11:8]);
      wgt  = ones ? 4'hF : (r[15:12] | r[19:16] | r[23:20]);
      sample_valid = 1'b0;
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      sample_valid   = 1'b1;
      sample_pixels  = pix;
      sample_weights = wgt;
      while (!sample_ready) begin
        @(posedge clk);
        #1;
      end
      @(posedge clk);
      #1;
      count_sample(pix, wgt);
    end
    sample_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_lanes();
    logic [31:0] rd;
    logic [31:0] exp;
    logic        err;
    for (int k = 0; k < 4; k++) begin
      for (int b = 0; b < 4; b++) begin
        exp[8 * b +: 8] = ref_count[4 * k + b];
      end
      apb_transfer(1'b0, 8'(`PE_REG_RESULT0 + 4 * k), 32'h0, rd, err);
      check_value($sformatf("RESULT%0d", k), rd, exp);
    end
  endtask

  task automatic wait_done();
    logic [31:0] status;
    logic        err;
    status = '0;
    while (status[1] == 1'b0) begin
      apb_transfer(1'b0, `PE_REG_STATUS, 32'h0, status, err);
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - mark);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic        err;
    int          mark;

    clk            = 1'b0;
    reset          = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    sample_valid   = 1'b0;
    sample_pixels  = '0;
    sample_weights = '0;
    seed           = 77358;
    for (int l = 0; l < `PE_LANES; l++) begin
      ref_count[l] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;

    mark = errors;
    apb_transfer(1'b0, `PE_REG_STATUS, 32'h0, rd, err);
    check_value("STATUS", rd, 32'h0);
    check_lanes();
    check_value("sample_ready", 32'(sample_ready), 32'h0);
    finish_test("reset state", mark);

    mark = errors;
    apb_transfer(1'b1, `PE_REG_LEN, 32'd20, rd, err);
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h1, rd, err);
    send_window(20, 1'b1, 1'b0);
    wait_done();
    check_lanes();
    apb_transfer(1'b0, `PE_REG_STATUS, 32'h0, rd, err);
    check_value("STATUS", rd, 32'h2);
    finish_test("all-ones window of 20", mark);

    mark = errors;
    apb_transfer(1'b1, `PE_REG_LEN, 32'd200, rd, err);
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h1, rd, err);
    send_window(200, 1'b0, 1'b1);
    wait_done();
    check_lanes();
    finish_test("random window of 200 with gaps", mark);

    // Second window on top of the first, lanes pass 255 here
    mark = errors;
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h1, rd, err);
    send_window(200, 1'b0, 1'b1);
    wait_done();
    check_lanes();
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h2, rd, err);
    check_value("pslverr", 32'(err), 32'h0);
    // Lanes are zero two edges after the access edge
    @(posedge clk);
    #1;
    for (int l = 0; l < `PE_LANES; l++) begin
      ref_count[l] = '0;
    end
    check_lanes();
    apb_transfer(1'b0, `PE_REG_STATUS, 32'h0, rd, err);
    check_value("STATUS", rd, 32'h0);
    finish_test("accumulate then clear", mark);

    mark = errors;
    apb_transfer(1'b1, `PE_REG_LEN, 32'd10, rd, err);
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h1, rd, err);
    check_value("pslverr", 32'(err), 32'h0);
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h1, rd, err);
    check_value("pslverr", 32'(err), 32'h1);
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h2, rd, err);
    check_value("pslverr", 32'(err), 32'h1);
    apb_transfer(1'b0, `PE_REG_LEN, 32'h0, rd, err);
    check_value("LEN", rd, 32'd10);
    send_window(10, 1'b0, 1'b0);
    wait_done();
    check_lanes();
    apb_transfer(1'b0, 8'h20, 32'h0, rd, err);
    check_value("pslverr", 32'(err), 32'h1);
    finish_test("busy and unmapped accesses", mark);

    // Valid held high, nothing may be taken
    mark = errors;
    apb_transfer(1'b1, `PE_REG_LEN, 32'd0, rd, err);
    sample_valid   = 1'b1;
    sample_pixels  = 4'hF;
    sample_weights = 4'hF;
    apb_transfer(1'b1, `PE_REG_CTRL, 32'h1, rd, err);
    wait_done();
    check_value("sample_ready", 32'(sample_ready), 32'h0);
    check_lanes();
    sample_valid = 1'b0;
    finish_test("zero-length window", mark);

    assert_fails = packed_pe_top_i.packed_pe_assertions_i.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/packed_pe_assertions.sv
`default_nettype none

module packed_pe_assertions (
  input wire                        clk,
  input wire                        reset,
  input wire                        pready,
  input wire                        sample_valid,
  input wire                        sample_ready,
  input wire                        busy,
  input wire                        done,
  input wire                        clear,
  input wire packed_pe_pkg::lanes_t lanes
);

  logic accept;
  int   fail_count = 0;

  assign accept = sample_valid && sample_ready;

  //////////////////////////////////////////////////////////////////////
  // Bus and stream rules
  //////////////////////////////////////////////////////////////////////
  a_ready_needs_busy: assert property (@(posedge clk) disable iff (reset)
    sample_ready |-> busy)
  else begin
    $error("sample_ready high while busy is low");
    fail_count++;
  end

  a_pready_high: assert property (@(posedge clk) disable iff (reset) pready)
  else begin
    $error("pready dropped low");
    fail_count++;
  end

  a_done_not_busy: assert property (@(posedge clk) disable iff (reset)
    !(done && busy))
  else begin
    $error("done and busy high together");
    fail_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // Pipeline timing
  //////////////////////////////////////////////////////////////////////
  // Last accept is the one after which ready drops, busy falls 3 edges later
  a_busy_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) == ($past(accept, 4) && !$past(sample_ready, 3)))
  else begin
    $error("busy did not fall three edges after the last accepted sample");
    fail_count++;
  end

  a_clear_zeroes: assert property (@(posedge clk) disable iff (reset)
    $past(clear, 2) |-> (lanes == '0))
  else begin
    $error("lanes not zero two edges after a clear");
    fail_count++;
  end

endmodule

bind packed_pe_top packed_pe_assertions packed_pe_assertions_i (
  .clk          (clk),
  .reset        (reset),
  .pready       (pready),
  .sample_valid (sample_valid),
  .sample_ready (sample_ready),
  .busy         (busy),
  .done         (done),
  .clear        (clear),
  .lanes        (lanes)
);

`default_nettype wire

//--- design/packed_pe_top.sv
`default_nettype none

`include "packed_pe_defines.svh"

module packed_pe_top (
  input  wire                    clk,
  input  wire                    reset,
  // APB
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire [`PE_APB_AW-1:0]   paddr,
  input  wire [`PE_APB_DW-1:0]   pwdata,
  output logic [`PE_APB_DW-1:0]  prdata,
  output logic                   pready,
  output logic                   pslverr,
  // Sample stream
  input  wire                    sample_valid,
  output logic                   sample_ready,
  input  wire [`PE_PIXELS-1:0]   sample_pixels,
  input  wire [`PE_WEIGHTS-1:0]  sample_weights
);

  import packed_pe_pkg::*;

  logic       start;
  logic       clear;
  logic       busy;
  logic       done;
  win_len_t   win_len;
  operand_a_t op_a;
  operand_b_t op_b;
  product_t   product;
  logic       mac_en;
  logic       mac_clear;
  lanes_t     lanes;

  pe_apb_regs pe_apb_regs_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (busy),
    .done    (done),
    .lanes   (lanes),
    .start   (start),
    .clear   (clear),
    .win_len (win_len)
  );

  mac_sequencer mac_sequencer_i (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .clear          (clear),
    .win_len        (win_len),
    .sample_valid   (sample_valid),
    .sample_pixels  (sample_pixels),
    .sample_weights (sample_weights),
    .sample_ready   (sample_ready),
    .op_a           (op_a),
    .op_b           (op_b),
    .mac_en         (mac_en),
    .mac_clear      (mac_clear),
    .busy           (busy),
    .done           (done)
  );

  // Two-stage multiplier between sequencer and lanes
  packed_mult packed_mult_i (
    .clk     (clk),
    .op_a    (op_a),
    .op_b    (op_b),
    .product (product)
  );

  packed_mac packed_mac_i (
    .clk       (clk),
    .reset     (reset),
    .mac_en    (mac_en),
    .mac_clear (mac_clear),
    .product   (product),
    .lanes     (lanes)
  );

endmodule

`default_nettype wire

//--- design/pe_apb_regs.sv
`default_nettype none

`include "packed_pe_defines.svh"

module pe_apb_regs (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [`PE_APB_AW-1:0]         paddr,
  input  wire [`PE_APB_DW-1:0]         pwdata,
  output logic [`PE_APB_DW-1:0]        prdata,
  output logic                         pready,
  output logic                         pslverr,
  input  wire                          busy,
  input  wire                          done,
  input  wire packed_pe_pkg::lanes_t   lanes,
  output logic                         start,
  output logic                         clear,
  output packed_pe_pkg::win_len_t      win_len
);

  localparam int LEN_W = $bits(win_len);

  logic access;
  logic wr_access;
  logic ctrl_busy;
  logic ctrl_sel;
  logic len_sel;
  logic bad_addr;
  logic bad_dir;
  logic ctrl_reject;
  logic ctrl_wr;
  logic len_wr;
  logic done_sticky;

  // No wait states
  assign pready = 1'b1;

  assign access    = psel && penable;
  assign wr_access = access && pwrite;

  // Start pulse in flight counts as busy
  assign ctrl_busy = busy || start;

  //////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    prdata   = '0;
    ctrl_sel = 1'b0;
    len_sel  = 1'b0;
    bad_addr = 1'b0;
    bad_dir  = 1'b0;
    case (paddr)
      `PE_REG_CTRL: begin
        ctrl_sel = 1'b1;
        bad_dir  = !pwrite;
      end
      `PE_REG_LEN: begin
        len_sel = 1'b1;
        prdata  = {{(`PE_APB_DW-LEN_W){1'b0}}, win_len};
      end
      `PE_REG_STATUS: begin
        prdata  = {{(`PE_APB_DW-2){1'b0}}, done_sticky, busy};
        bad_dir = pwrite;
      end
      // Lane 4k ends up in bits 7:0
      `PE_REG_RESULT0: begin
        prdata  = lanes[3:0];
        bad_dir = pwrite;
      end
      `PE_REG_RESULT1: begin
        prdata  = lanes[7:4];
        bad_dir = pwrite;
      end
      `PE_REG_RESULT2: begin
        prdata  = lanes[11:8];
        bad_dir = pwrite;
      end
      `PE_REG_RESULT3: begin
        prdata  = lanes[15:12];
        bad_dir = pwrite;
      end
      default: begin
        bad_addr = 1'b1;
      end
    endcase
  end

  assign ctrl_reject = ctrl_sel && pwrite && ctrl_busy;
  assign pslverr     = access && (bad_addr || bad_dir || ctrl_reject);

  assign ctrl_wr = wr_access && ctrl_sel && !ctrl_busy;
  assign len_wr  = wr_access && len_sel;

  //////////////////////////////////////////////////////////////////////
  // Registers and command pulses
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      start       <= 1'b0;
      clear       <= 1'b0;
      win_len     <= '0;
      done_sticky <= 1'b0;
    end else begin
      start <= 1'b0;
      clear <= 1'b0;

      if (ctrl_wr) begin
        start <= pwdata[`PE_CTRL_START];
        clear <= pwdata[`PE_CTRL_CLEAR];
        // New command drops the old done
        if (pwdata[`PE_CTRL_START] || pwdata[`PE_CTRL_CLEAR]) begin
          done_sticky <= 1'b0;
        end
      end

      if (len_wr) begin
        win_len <= pwdata[LEN_W-1:0];
      end

      if (done) begin
        done_sticky <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mac_sequencer.sv
`default_nettype none

`include "packed_pe_defines.svh"

module mac_sequencer (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            start,
  input  wire                            clear,
  input  wire packed_pe_pkg::win_len_t   win_len,
  input  wire                            sample_valid,
  input  wire [`PE_PIXELS-1:0]           sample_pixels,
  input  wire [`PE_WEIGHTS-1:0]          sample_weights,
  output logic                           sample_ready,
  output packed_pe_pkg::operand_a_t      op_a,
  output packed_pe_pkg::operand_b_t      op_b,
  output logic                           mac_en,
  output logic                           mac_clear,
  output logic                           busy,
  output logic                           done
);

  import packed_pe_pkg::*;

  win_len_t   remaining;
  logic [2:0] strobe_sr;
  logic       accept;
  logic       last_out;
  operand_a_t pix_packed;
  operand_b_t wgt_packed;

  assign sample_ready = busy && (remaining != '0);
  assign accept       = sample_valid && sample_ready;

  // Strobe is aligned with the product two edges after the operands
  assign mac_en = strobe_sr[2];

  // Final strobe leaves the shift with nothing behind it
  assign last_out = strobe_sr[2] && (strobe_sr[1:0] == 2'b00) && (remaining == '0);

  //////////////////////////////////////////////////////////////////////
  // Operand packing
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    pix_packed = '0;
    wgt_packed = '0;
    for (int i = 0; i < `PE_PIXELS; i++) begin
      pix_packed[`PE_PIXEL_STRIDE*i] = sample_pixels[i];
    end
    for (int j = 0; j < `PE_WEIGHTS; j++) begin
      wgt_packed[`PE_WEIGHT_STRIDE*j] = sample_weights[j];
    end
  end

  // Operands only change on an accepted sample
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a <= pix_packed;
      op_b <= wgt_packed;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Window control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
      strobe_sr <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
      mac_clear <= 1'b0;
    end else begin
      strobe_sr <= {strobe_sr[1:0], accept};
      mac_clear <= clear;
      // done is a single-cycle pulse
      done      <= 1'b0;

      if (start && !busy) begin
        remaining <= win_len;
        if (win_len == '0) begin
          done <= 1'b1;
        end else begin
          busy <= 1'b1;
        end
      end else begin
        if (accept) begin
          remaining <= remaining - win_len_t'(1);
        end
        // Last sample lands in the lanes on this edge
        if (last_out) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/packed_mac.sv
`default_nettype none

`include "packed_pe_defines.svh"

module packed_mac (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          mac_en,
  input  wire                          mac_clear,
  input  wire packed_pe_pkg::product_t product,
  output packed_pe_pkg::lanes_t        lanes
);

  import packed_pe_pkg::*;

  localparam int FIELD_W  = `PE_FIELD_W;
  localparam int HEADROOM = `PE_HEADROOM;
  localparam int LANES    = `PE_LANES;

  // Per-lane addend, field widened to the lane width
  lane_acc_t addend [LANES];

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////
  // Field k of the product belongs to lane k.
  // Each field is one pixel-by-weight product, so no carries cross fields
  for (genvar k = 0; k < LANES; k++) begin : g_field
    logic [FIELD_W-1:0] field;

    assign field     = product[FIELD_W*k +: FIELD_W];
    assign addend[k] = {{HEADROOM{field[FIELD_W-1]}}, field};
  end

  //////////////////////////////////////////////////////////////////////
  // Lane accumulators
  //////////////////////////////////////////////////////////////////////
  // Lanes wrap modulo 256
  always_ff @(posedge clk) begin
    if (reset) begin
      lanes <= '0;
    end else if (mac_clear) begin
      lanes <= '0;
    end else if (mac_en) begin
      for (int k = 0; k < LANES; k++) begin
        lanes[k] <= lanes[k] + addend[k];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/packed_mult.sv
`default_nettype none

module packed_mult (
  input  wire                            clk,
  input  wire packed_pe_pkg::operand_a_t op_a,
  input  wire packed_pe_pkg::operand_b_t op_b,
  output packed_pe_pkg::product_t        product
);

  import packed_pe_pkg::*;

  operand_a_t a_q;
  operand_b_t b_q;

  //////////////////////////////////////////////////////////////////////
  // Stage 1: operand registers, as on the A/B ports of a DSP slice
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    a_q <= op_a;
    b_q <= op_b;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2: full unsigned product
  //////////////////////////////////////////////////////////////////////
  // Both operands zero-extended to product width first
  always_ff @(posedge clk) begin
    product <= product_t'(a_q) * product_t'(b_q);
  end

endmodule

`default_nettype wire

//--- design/packed_pe_pkg.sv
`default_nettype none

`include "packed_pe_defines.svh"

package packed_pe_pkg;

  // Pixel i at bit 2i, upper bits stay zero
  typedef logic [20:0] operand_a_t;

  // Weight j at bit 8j, so the top weight needs bit 24
  typedef logic [24:0] operand_b_t;

  // Fields 0..15 in bits 31:0, top bit always zero
  typedef logic [32:0] product_t;

  // One accumulator per pixel/weight pair
  typedef logic [`PE_LANE_W-1:0] lane_acc_t;

  // Lane k sits in bits 8k+7:8k
  typedef lane_acc_t [`PE_LANES-1:0] lanes_t;

  // Samples per window
  typedef logic [15:0] win_len_t;

endpackage

`default_nettype wire

//--- design/packed_pe_defines.svh
`ifndef PACKED_PE_DEFINES_SVH
`define PACKED_PE_DEFINES_SVH

// Lane geometry
`define PE_HEADROOM       6
`define PE_FIELD_W        2
`define PE_LANE_W         (`PE_FIELD_W + `PE_HEADROOM)

`define PE_PIXELS         4
`define PE_WEIGHTS        4
`define PE_LANES          (`PE_PIXELS * `PE_WEIGHTS)

// Bit spacing of pixels in operand A and weights in operand B
`define PE_PIXEL_STRIDE   2
`define PE_WEIGHT_STRIDE  8

// APB bus
`define PE_APB_AW         8
`define PE_APB_DW         32

`define PE_REG_CTRL       8'h00
`define PE_REG_LEN        8'h04
`define PE_REG_STATUS     8'h08
`define PE_REG_RESULT0    8'h10
`define PE_REG_RESULT1    8'h14
`define PE_REG_RESULT2    8'h18
`define PE_REG_RESULT3    8'h1C

// CTRL bits
`define PE_CTRL_START     0
`define PE_CTRL_CLEAR     1

`endif
